// File: act_format.sv
`timescale 1ns/100ps
`default_nettype none

module act_format
    import decoder_pkg::*;
(
    input  wire layer_state_t layer_state,
    input  wire data_t        mult_a_out_round,
    input  wire data_t        mult_b_out_round,
    output data_t             decoder_out,
    output data_pair_t        decoder_out_cat
);

    data_t relu_a;
    data_t relu_b;

    // negative values clamp to zero
    assign relu_a = mult_a_out_round[DATA_W-1] ? '0 : mult_a_out_round;
    assign relu_b = mult_b_out_round[DATA_W-1] ? '0 : mult_b_out_round;

    always_comb begin
        decoder_out     = '0;
        decoder_out_cat = '0;
        case (layer_state)
            ST_DCNN1: decoder_out = mult_a_out_round;      // raw
            ST_CNN11,
            ST_CNN12: decoder_out = relu_a;
            ST_DCNN2: decoder_out_cat = {mult_b_out_round, mult_a_out_round};
            ST_CNN21: decoder_out_cat = {relu_b, relu_a};
            default: begin
                decoder_out     = '0;
                decoder_out_cat = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: argmax_classifier.sv
`timescale 1ns/100ps
`default_nettype none

module argmax_classifier
    import decoder_pkg::*;
(
    input  wire               wclk,
    input  wire               rst_n,
    input  wire layer_state_t layer_state,
    input  wire               pe_out_vld,
    input  wire               pair_first,
    input  wire data_t        mult_a_out_round,
    input  wire data_t        mult_b_out_round,
    output class_t            softmax_out,
    output logic              class_vld
);

    data_t  a1_hold;    // first beat of the pair
    data_t  b1_hold;
    data_t  a_max;
    data_t  b_max;
    logic   a1_wins;
    logic   b1_wins;
    logic   beat_cnn22;
    class_t class_next;

    assign beat_cnn22 = pe_out_vld && (layer_state == ST_CNN22);

    always_ff @(posedge wclk or negedge rst_n) begin
        if (!rst_n) begin
            a1_hold <= '0;
            b1_hold <= '0;
        end else if (beat_cnn22 && pair_first) begin
            a1_hold <= mult_a_out_round;
            b1_hold <= mult_b_out_round;
        end
    end

    // ties go to the second beat, and lane b wins a tie between lanes
    always_comb begin
        a1_wins = a1_hold > mult_a_out_round;
        b1_wins = b1_hold > mult_b_out_round;
        a_max   = a1_wins ? a1_hold : mult_a_out_round;
        b_max   = b1_wins ? b1_hold : mult_b_out_round;
        if (a_max > b_max) begin
            class_next = a1_wins ? 2'b00 : 2'b10;
        end else begin
            class_next = b1_wins ? 2'b01 : 2'b11;
        end
    end

    always_ff @(posedge wclk or negedge rst_n) begin
        if (!rst_n) begin
            softmax_out <= '0;
            class_vld   <= 1'b0;
        end else begin
            class_vld <= beat_cnn22 && !pair_first;
            if (beat_cnn22 && !pair_first) softmax_out <= class_next;   // held until next pair
        end
    end

endmodule

`default_nettype wire

// File: decoder_checker.sv
`timescale 1ns/100ps
`default_nettype none

module decoder_checker
    import decoder_pkg::*;
(
    input wire               wclk,
    input wire               rst_n,
    input wire layer_state_t layer_state,
    input wire               layer_rdy,
    input wire               decoder_done,
    input wire               class_vld,
    input wire               pe_out_vld
);

    // done lasts one cycle and drops back to idle
    assert property (@(posedge wclk) disable iff (!rst_n)
        decoder_done |=> !decoder_done && (layer_state == ST_IDLE))
        else $error("decoder_done not a single cycle followed by idle");

    assert property (@(posedge wclk) disable iff (!rst_n)
        layer_rdy |=> !layer_rdy)
        else $error("layer_rdy high for two cycles");

    // class result only right after a cnn22 beat
    assert property (@(posedge wclk) disable iff (!rst_n)
        class_vld |-> $past(pe_out_vld && (layer_state == ST_CNN22)))
        else $error("class_vld without a cnn22 beat");

endmodule

bind decoder_top decoder_checker decoder_checker_i (
    .wclk         (wclk),
    .rst_n        (rst_n),
    .layer_state  (layer_state),
    .layer_rdy    (layer_rdy),
    .decoder_done (decoder_done),
    .class_vld    (class_vld),
    .pe_out_vld   (pe_out_vld)
);

`default_nettype wire

// File: decoder_pkg.sv
`default_nettype none

package decoder_pkg;

    // datapath and address widths
    localparam int DATA_W         = 8;
    localparam int W_ADDR_W       = 13;
    localparam int W_ADDR_SMALL_W = 9;   // dcnn2 weight sram is 512 deep
    localparam int CFG_ADDR_W     = 10;
    localparam int CLASS_W        = 2;
    localparam int BEAT_CNT_W     = 13;  // holds 4095 for the largest layer

    typedef logic signed [DATA_W-1:0]   data_t;
    typedef logic [2*DATA_W-1:0]        data_pair_t;    // {lane b, lane a}
    typedef logic [W_ADDR_W-1:0]        w_addr_t;
    typedef logic [W_ADDR_SMALL_W-1:0]  w_addr_small_t;
    typedef logic [CFG_ADDR_W-1:0]      cfg_addr_t;
    typedef logic [CLASS_W-1:0]         class_t;
    typedef logic [BEAT_CNT_W-1:0]      beat_cnt_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_DCNN1,
        ST_CNN11,
        ST_CNN12,
        ST_DCNN2,
        ST_CNN21,
        ST_CNN22,
        ST_DONE
    } layer_state_t;

    // layer geometry
    localparam int DCNN_KS      = 8;
    localparam int DCNN_STRIDE  = 2;
    localparam int DCNN_PADDING = 3;
    localparam int CNN_KS       = 5;
    localparam int CNN_PADDING  = 2;

    localparam int DCNN1_LENGTH_IN  = 64;
    localparam int DCNN1_LENGTH_OUT =
        DCNN_STRIDE * (DCNN1_LENGTH_IN - 1) - 2 * DCNN_PADDING + DCNN_KS;   // 128
    localparam int CNN11_LENGTH_OUT = DCNN1_LENGTH_OUT + 2 * CNN_PADDING - CNN_KS + 1;
    localparam int CNN12_LENGTH_OUT = CNN11_LENGTH_OUT + 2 * CNN_PADDING - CNN_KS + 1;
    localparam int DCNN2_LENGTH_OUT =
        DCNN_STRIDE * (CNN12_LENGTH_OUT - 1) - 2 * DCNN_PADDING + DCNN_KS;  // 256
    localparam int CNN21_LENGTH_OUT = DCNN2_LENGTH_OUT + 2 * CNN_PADDING - CNN_KS + 1;
    localparam int CNN22_LENGTH_OUT = CNN21_LENGTH_OUT + 2 * CNN_PADDING - CNN_KS + 1;

    localparam int DCNN1_CHOUT = 32;
    localparam int CNN11_CHOUT = 32;
    localparam int CNN12_CHOUT = 16;
    localparam int DCNN2_CHOUT = 8;
    localparam int CNN21_CHOUT = 8;
    localparam int CNN22_CHOUT = 4;

    // output beats of the pe array per layer
    localparam int LANES_ONE = 1;
    localparam int LANES_TWO = 2;

    localparam int BEATS_DCNN1 = DCNN1_LENGTH_OUT * DCNN1_CHOUT / LANES_ONE;  // 4096
    localparam int BEATS_CNN11 = CNN11_LENGTH_OUT * CNN11_CHOUT / LANES_ONE;  // 4096
    localparam int BEATS_CNN12 = CNN12_LENGTH_OUT * CNN12_CHOUT / LANES_ONE;  // 2048
    localparam int BEATS_DCNN2 = DCNN2_LENGTH_OUT * DCNN2_CHOUT / LANES_TWO;  // 1024
    localparam int BEATS_CNN21 = CNN21_LENGTH_OUT * CNN21_CHOUT / LANES_TWO;  // 1024
    localparam int BEATS_CNN22 = CNN22_LENGTH_OUT * CNN22_CHOUT / LANES_TWO;  // 512

    localparam int BEATS_TOTAL = BEATS_DCNN1 + BEATS_CNN11 + BEATS_CNN12 +
                                 BEATS_DCNN2 + BEATS_CNN21 + BEATS_CNN22;    // 12800

endpackage

`default_nettype wire

// File: decoder_top.sv
`timescale 1ns/100ps
`default_nettype none

module decoder_top
    import decoder_pkg::*;
(
    input  wire                wclk,
    input  wire                rst_n,
    input  wire                decoder_rdy,
    input  wire                pe_out_vld,
    input  wire data_t         mult_a_out_round,
    input  wire data_t         mult_b_out_round,
    input  wire w_addr_t       addr_dcnn1_w_init,
    input  wire w_addr_t       addr_cnn11_w_init,
    input  wire w_addr_t       addr_cnn12_w_init,
    input  wire w_addr_small_t addr_dcnn2_w_init,
    input  wire w_addr_t       addr_cnn21_w_init,
    input  wire w_addr_t       addr_cnn22_w_init,
    input  wire cfg_addr_t     addr_dcnn1_scales_init,
    input  wire cfg_addr_t     addr_cnn11_scales_init,
    input  wire cfg_addr_t     addr_cnn12_scales_init,
    input  wire cfg_addr_t     addr_dcnn2_scales_init,
    input  wire cfg_addr_t     addr_cnn21_scales_init,
    input  wire cfg_addr_t     addr_cnn22_scales_init,
    input  wire cfg_addr_t     addr_cnn11_b_init,
    input  wire cfg_addr_t     addr_cnn12_b_init,
    input  wire cfg_addr_t     addr_cnn21_b_init,
    input  wire cfg_addr_t     addr_cnn22_b_init,
    output layer_state_t       layer_state,
    output logic               layer_rdy,
    output logic               decoder_done,
    output w_addr_t            addr_w_base,
    output cfg_addr_t          addr_b_base,
    output cfg_addr_t          addr_scale_base,
    output data_t              decoder_out,
    output data_pair_t         decoder_out_cat,
    output class_t             softmax_out,
    output logic               class_vld
);

    layer_state_t layer_state_next;
    logic         layer_done;
    logic         pair_first;

    layer_sequencer u_layer_sequencer (
        .wclk             (wclk),
        .rst_n            (rst_n),
        .decoder_rdy      (decoder_rdy),
        .layer_done       (layer_done),
        .layer_state      (layer_state),
        .layer_state_next (layer_state_next),
        .layer_rdy        (layer_rdy),
        .decoder_done     (decoder_done)
    );

    layer_beat_counter u_layer_beat_counter (
        .wclk        (wclk),
        .rst_n       (rst_n),
        .layer_state (layer_state),
        .pe_out_vld  (pe_out_vld),
        .layer_done  (layer_done),
        .pair_first  (pair_first)
    );

    layer_addr_select u_layer_addr_select (
        .layer_state_next       (layer_state_next),
        .addr_dcnn1_w_init      (addr_dcnn1_w_init),
        .addr_cnn11_w_init      (addr_cnn11_w_init),
        .addr_cnn12_w_init      (addr_cnn12_w_init),
        .addr_cnn21_w_init      (addr_cnn21_w_init),
        .addr_cnn22_w_init      (addr_cnn22_w_init),
        .addr_dcnn2_w_init      (addr_dcnn2_w_init),
        .addr_dcnn1_scales_init (addr_dcnn1_scales_init),
        .addr_cnn11_scales_init (addr_cnn11_scales_init),
        .addr_cnn12_scales_init (addr_cnn12_scales_init),
        .addr_dcnn2_scales_init (addr_dcnn2_scales_init),
        .addr_cnn21_scales_init (addr_cnn21_scales_init),
        .addr_cnn22_scales_init (addr_cnn22_scales_init),
        .addr_cnn11_b_init      (addr_cnn11_b_init),
        .addr_cnn12_b_init      (addr_cnn12_b_init),
        .addr_cnn21_b_init      (addr_cnn21_b_init),
        .addr_cnn22_b_init      (addr_cnn22_b_init),
        .addr_w_base            (addr_w_base),
        .addr_b_base            (addr_b_base),
        .addr_scale_base        (addr_scale_base)
    );

    act_format u_act_format (
        .layer_state      (layer_state),
        .mult_a_out_round (mult_a_out_round),
        .mult_b_out_round (mult_b_out_round),
        .decoder_out      (decoder_out),
        .decoder_out_cat  (decoder_out_cat)
    );

    argmax_classifier u_argmax_classifier (
        .wclk             (wclk),
        .rst_n            (rst_n),
        .layer_state      (layer_state),
        .pe_out_vld       (pe_out_vld),
        .pair_first       (pair_first),
        .mult_a_out_round (mult_a_out_round),
        .mult_b_out_round (mult_b_out_round),
        .softmax_out      (softmax_out),
        .class_vld        (class_vld)
    );

endmodule

`default_nettype wire

// File: layer_addr_select.sv
`timescale 1ns/100ps
`default_nettype none

module layer_addr_select
    import decoder_pkg::*;
(
    input  wire layer_state_t  layer_state_next,
    input  wire w_addr_t       addr_dcnn1_w_init,
    input  wire w_addr_t       addr_cnn11_w_init,
    input  wire w_addr_t       addr_cnn12_w_init,
    input  wire w_addr_t       addr_cnn21_w_init,
    input  wire w_addr_t       addr_cnn22_w_init,
    input  wire w_addr_small_t addr_dcnn2_w_init,
    input  wire cfg_addr_t     addr_dcnn1_scales_init,
    input  wire cfg_addr_t     addr_cnn11_scales_init,
    input  wire cfg_addr_t     addr_cnn12_scales_init,
    input  wire cfg_addr_t     addr_dcnn2_scales_init,
    input  wire cfg_addr_t     addr_cnn21_scales_init,
    input  wire cfg_addr_t     addr_cnn22_scales_init,
    input  wire cfg_addr_t     addr_cnn11_b_init,
    input  wire cfg_addr_t     addr_cnn12_b_init,
    input  wire cfg_addr_t     addr_cnn21_b_init,
    input  wire cfg_addr_t     addr_cnn22_b_init,
    output w_addr_t            addr_w_base,
    output cfg_addr_t          addr_b_base,
    output cfg_addr_t          addr_scale_base
);

    // driven from the next state so the bases settle one cycle early
    always_comb begin
        case (layer_state_next)
            ST_CNN11: begin
                addr_w_base     = addr_cnn11_w_init;
                addr_b_base     = addr_cnn11_b_init;
                addr_scale_base = addr_cnn11_scales_init;
            end
            ST_CNN12: begin
                addr_w_base     = addr_cnn12_w_init;
                addr_b_base     = addr_cnn12_b_init;
                addr_scale_base = addr_cnn12_scales_init;
            end
            ST_DCNN2: begin
                addr_w_base     = w_addr_t'(addr_dcnn2_w_init);   // zero-extended from the small sram
                addr_b_base     = '0;                             // no bias in transposed conv
                addr_scale_base = addr_dcnn2_scales_init;
            end
            ST_CNN21: begin
                addr_w_base     = addr_cnn21_w_init;
                addr_b_base     = addr_cnn21_b_init;
                addr_scale_base = addr_cnn21_scales_init;
            end
            ST_CNN22: begin
                addr_w_base     = addr_cnn22_w_init;
                addr_b_base     = addr_cnn22_b_init;
                addr_scale_base = addr_cnn22_scales_init;
            end
            default: begin
                // dcnn1 and also idle or done so the first layer is ready
                addr_w_base     = addr_dcnn1_w_init;
                addr_b_base     = '0;
                addr_scale_base = addr_dcnn1_scales_init;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: layer_beat_counter.sv
`timescale 1ns/100ps
`default_nettype none

module layer_beat_counter
    import decoder_pkg::*;
(
    input  wire               wclk,
    input  wire               rst_n,
    input  wire layer_state_t layer_state,
    input  wire               pe_out_vld,
    output logic              layer_done,
    output logic              pair_first
);

    beat_cnt_t beat_cnt;
    beat_cnt_t beat_last;   // index of the final beat of this layer
    logic      in_layer;

    always_comb begin
        in_layer  = 1'b1;
        beat_last = '0;
        case (layer_state)
            ST_DCNN1: beat_last = beat_cnt_t'(BEATS_DCNN1 - 1);
            ST_CNN11: beat_last = beat_cnt_t'(BEATS_CNN11 - 1);
            ST_CNN12: beat_last = beat_cnt_t'(BEATS_CNN12 - 1);
            ST_DCNN2: beat_last = beat_cnt_t'(BEATS_DCNN2 - 1);
            ST_CNN21: beat_last = beat_cnt_t'(BEATS_CNN21 - 1);
            ST_CNN22: beat_last = beat_cnt_t'(BEATS_CNN22 - 1);
            default:  in_layer  = 1'b0;     // idle and done
        endcase
    end

    assign layer_done = in_layer && pe_out_vld && (beat_cnt == beat_last);

    always_ff @(posedge wclk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (!in_layer || layer_done) begin
            beat_cnt <= '0;
        end else if (pe_out_vld) begin
            beat_cnt <= beat_cnt + 1'b1;   // gaps just hold the count
        end
    end

    // even count means the first beat of a cnn22 pair
    assign pair_first = ~beat_cnt[0];

endmodule

`default_nettype wire

// File: layer_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module layer_sequencer
    import decoder_pkg::*;
(
    input  wire          wclk,
    input  wire          rst_n,
    input  wire          decoder_rdy,
    input  wire          layer_done,
    output layer_state_t layer_state,
    output layer_state_t layer_state_next,
    output logic         layer_rdy,
    output logic         decoder_done
);

    logic start_layer;

    assign start_layer = (layer_state == ST_IDLE) && decoder_rdy;  // decoder_rdy only seen in idle

    always_comb begin
        layer_state_next = layer_state;
        case (layer_state)
            ST_IDLE: begin
                if (decoder_rdy) layer_state_next = ST_DCNN1;
            end
            ST_DCNN1: begin
                if (layer_done) layer_state_next = ST_CNN11;
            end
            ST_CNN11: begin
                if (layer_done) layer_state_next = ST_CNN12;
            end
            ST_CNN12: begin
                if (layer_done) layer_state_next = ST_DCNN2;
            end
            ST_DCNN2: begin
                if (layer_done) layer_state_next = ST_CNN21;
            end
            ST_CNN21: begin
                if (layer_done) layer_state_next = ST_CNN22;
            end
            ST_CNN22: begin
                if (layer_done) layer_state_next = ST_DONE;
            end
            ST_DONE:  layer_state_next = ST_IDLE;       // single cycle
            default:  layer_state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge wclk or negedge rst_n) begin
        if (!rst_n) begin
            layer_state <= ST_IDLE;
            layer_rdy   <= 1'b0;
        end else begin
            layer_state <= layer_state_next;
            // start strobe for the pe array except after the last layer
            layer_rdy   <= start_layer | (layer_done & (layer_state_next != ST_DONE));
        end
    end

    assign decoder_done = (layer_state == ST_DONE);

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_decoder_top \
    -f vlog.f -o sim_decoder

./obj_dir/sim_decoder > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST PASSED$" sim.log; then
    exit 0
else
    exit 1
fi

// File: tb_decoder_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_decoder_top
    import decoder_pkg::*;
();

    localparam int TIMEOUT_CYCLES = BEATS_TOTAL * 3 + 1000;

    logic          wclk;
    logic          rst_n;
    logic          decoder_rdy;
    logic          pe_out_vld;
    data_t         mult_a_out_round;
    data_t         mult_b_out_round;
    w_addr_t       addr_dcnn1_w_init;
    w_addr_t       addr_cnn11_w_init;
    w_addr_t       addr_cnn12_w_init;
    w_addr_small_t addr_dcnn2_w_init;
    w_addr_t       addr_cnn21_w_init;
    w_addr_t       addr_cnn22_w_init;
    cfg_addr_t     addr_dcnn1_scales_init;
    cfg_addr_t     addr_cnn11_scales_init;
    cfg_addr_t     addr_cnn12_scales_init;
    cfg_addr_t     addr_dcnn2_scales_init;
    cfg_addr_t     addr_cnn21_scales_init;
    cfg_addr_t     addr_cnn22_scales_init;
    cfg_addr_t     addr_cnn11_b_init;
    cfg_addr_t     addr_cnn12_b_init;
    cfg_addr_t     addr_cnn21_b_init;
    cfg_addr_t     addr_cnn22_b_init;
    layer_state_t  layer_state;
    logic          layer_rdy;
    logic          decoder_done;
    w_addr_t       addr_w_base;
    cfg_addr_t     addr_b_base;
    cfg_addr_t     addr_scale_base;
    data_t         decoder_out;
    data_pair_t    decoder_out_cat;
    class_t        softmax_out;
    logic          class_vld;

    integer seed;
    int     errors;
    int     cycle_cnt;
    logic   cls_pending;    // a class result is due at the next sample
    class_t cls_expect;
    data_t  a1_model;
    data_t  b1_model;

    decoder_top decoder_top_i (.*);

    initial begin
        wclk = 1'b0;
        forever #20 wclk = ~wclk;
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("FAIL at %0t: %s got %0h expected %0h", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge wclk);
        #2;     // inputs change just after the edge
    endtask

    function automatic data_t relu(input data_t v);
        return (v < 0) ? data_t'(0) : v;
    endfunction

    task automatic check_addresses(input layer_state_t st);
        w_addr_t   exp_w;
        cfg_addr_t exp_b;
        cfg_addr_t exp_s;
        exp_w = addr_dcnn1_w_init;
        exp_b = '0;
        exp_s = addr_dcnn1_scales_init;
        case (st)
            ST_CNN11: begin
                exp_w = addr_cnn11_w_init;
                exp_b = addr_cnn11_b_init;
                exp_s = addr_cnn11_scales_init;
            end
            ST_CNN12: begin
                exp_w = addr_cnn12_w_init;
                exp_b = addr_cnn12_b_init;
                exp_s = addr_cnn12_scales_init;
            end
            ST_DCNN2: begin
                exp_w = {4'b0, addr_dcnn2_w_init};
                exp_s = addr_dcnn2_scales_init;
            end
            ST_CNN21: begin
                exp_w = addr_cnn21_w_init;
                exp_b = addr_cnn21_b_init;
                exp_s = addr_cnn21_scales_init;
            end
            ST_CNN22: begin
                exp_w = addr_cnn22_w_init;
                exp_b = addr_cnn22_b_init;
                exp_s = addr_cnn22_scales_init;
            end
            default: ;
        endcase
        check(32'(addr_w_base), 32'(exp_w), "weight base");
        check(32'(addr_b_base), 32'(exp_b), "bias base");
        check(32'(addr_scale_base), 32'(exp_s), "scale base");
    endtask

    task automatic check_format(input layer_state_t st, input data_t a, input data_t b);
        data_t      exp_out;
        data_pair_t exp_cat;
        exp_out = '0;
        exp_cat = '0;
        case (st)
            ST_DCNN1:           exp_out = a;
            ST_CNN11, ST_CNN12: exp_out = relu(a);
            ST_DCNN2:           exp_cat = {b, a};
            ST_CNN21:           exp_cat = {relu(b), relu(a)};
            default: ;
        endcase
        check(32'(decoder_out), 32'(exp_out), "decoder_out");
        check(32'(decoder_out_cat), 32'(exp_cat), "decoder_out_cat");
    endtask

    // class result due from the previous edge
    task automatic check_class();
        check(32'(class_vld), 32'(cls_pending), "class_vld");
        if (cls_pending) check(32'(softmax_out), 32'(cls_expect), "softmax_out");
        cls_pending = 1'b0;
    endtask

    // largest value wins and a tie goes to the later of a1, a2, b1, b2
    task automatic model_argmax(input data_t a2, input data_t b2);
        data_t best;
        best       = a1_model;
        cls_expect = 2'b00;
        if (a2 >= best) begin
            best       = a2;
            cls_expect = 2'b10;
        end
        if (b1_model >= best) begin
            best       = b1_model;
            cls_expect = 2'b01;
        end
        if (b2 >= best) begin
            cls_expect = 2'b11;
        end
        cls_pending = 1'b1;
    endtask

    task automatic run_layer(input layer_state_t st, input int beats, input layer_state_t nxt);
        int    i;
        logic  first_cycle;
        data_t a;
        data_t b;
        int    r;
        i = 0;
        first_cycle = 1'b1;
        check(32'(layer_rdy), 32'd1, "layer_rdy on layer entry");
        while (i < beats) begin
            check(32'(layer_state), 32'(st), "state held inside layer");
            if (first_cycle) check_addresses(st);
            if (!first_cycle) check(32'(layer_rdy), 32'd0, "layer_rdy after entry");
            if (($random(seed) & 3) == 0) begin
                pe_out_vld = 1'b0;      // gap
                #1;
                check_class();
            end else begin
                a = data_t'($random(seed));
                b = data_t'($random(seed));
                r = $random(seed) & 7;
                if (st == ST_CNN22 && i[0] && r == 0) a = a1_model;
                if (st == ST_CNN22 && i[0] && r == 1) b = b1_model;
                if (st == ST_CNN22 && r == 2) b = a;
                pe_out_vld       = 1'b1;
                mult_a_out_round = a;
                mult_b_out_round = b;
                #1;
                check_class();
                check_format(st, a, b);
                if (st == ST_CNN22 && !i[0]) begin
                    a1_model = a;
                    b1_model = b;
                end else if (st == ST_CNN22) begin
                    model_argmax(a, b);
                end
                i++;
            end
            first_cycle = 1'b0;
            next_cycle();
        end
        pe_out_vld = 1'b0;
        check(32'(layer_state), 32'(nxt), "state after last beat");
    endtask

    task automatic test_reset();
        check(32'(layer_state), 32'(ST_IDLE), "state after reset");
        check(32'(layer_rdy), 32'd0, "layer_rdy after reset");
        check(32'(decoder_done), 32'd0, "decoder_done after reset");
        check(32'(class_vld), 32'd0, "class_vld after reset");
        check(32'(softmax_out), 32'd0, "softmax_out after reset");
        check_addresses(ST_IDLE);
        repeat (10) begin
            next_cycle();
            check(32'(layer_state), 32'(ST_IDLE), "idle without decoder_rdy");
        end
    endtask

    // one full pass that also checks addresses, format and argmax
    task automatic test_layer_order();
        decoder_rdy = 1'b1;
        next_cycle();
        decoder_rdy = 1'b0;
        check(32'(layer_state), 32'(ST_DCNN1), "start on decoder_rdy");
        run_layer(ST_DCNN1, BEATS_DCNN1, ST_CNN11);
        run_layer(ST_CNN11, BEATS_CNN11, ST_CNN12);
        run_layer(ST_CNN12, BEATS_CNN12, ST_DCNN2);
        run_layer(ST_DCNN2, BEATS_DCNN2, ST_CNN21);
        run_layer(ST_CNN21, BEATS_CNN21, ST_CNN22);
        run_layer(ST_CNN22, BEATS_CNN22, ST_DONE);
        check(32'(decoder_done), 32'd1, "decoder_done in done");
        check(32'(layer_rdy), 32'd0, "no layer_rdy into done");
        #1;
        check_class();
        next_cycle();
        check(32'(layer_state), 32'(ST_IDLE), "idle after done");
        check(32'(decoder_done), 32'd0, "decoder_done one cycle");
    endtask

    initial begin
        seed        = 32'h1a2023ca;
        errors      = 0;
        cls_pending = 1'b0;
        cls_expect  = '0;
        a1_model    = '0;
        b1_model    = '0;
        rst_n       = 1'b0;
        decoder_rdy = 1'b0;
        pe_out_vld  = 1'b0;
        mult_a_out_round = '0;
        mult_b_out_round = '0;
        // upper bits tag the layer to keep the bases distinct
        addr_dcnn1_w_init = {3'd1, 10'($random(seed))};
        addr_cnn11_w_init = {3'd2, 10'($random(seed))};
        addr_cnn12_w_init = {3'd3, 10'($random(seed))};
        addr_dcnn2_w_init = {1'b1, 8'($random(seed))};     // msb set to see zero-extension
        addr_cnn21_w_init = {3'd5, 10'($random(seed))};
        addr_cnn22_w_init = {3'd6, 10'($random(seed))};
        addr_dcnn1_scales_init = {4'd1, 6'($random(seed))};
        addr_cnn11_scales_init = {4'd2, 6'($random(seed))};
        addr_cnn12_scales_init = {4'd3, 6'($random(seed))};
        addr_dcnn2_scales_init = {4'd4, 6'($random(seed))};
        addr_cnn21_scales_init = {4'd5, 6'($random(seed))};
        addr_cnn22_scales_init = {4'd6, 6'($random(seed))};
        addr_cnn11_b_init = {4'd7, 6'($random(seed))};
        addr_cnn12_b_init = {4'd8, 6'($random(seed))};
        addr_cnn21_b_init = {4'd9, 6'($random(seed))};
        addr_cnn22_b_init = {4'd10, 6'($random(seed))};
        repeat (3) @(posedge wclk);
        #2;
        rst_n = 1'b1;
        test_reset();
        test_layer_order();
        $display("run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge wclk);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
decoder_pkg.sv
layer_sequencer.sv
layer_beat_counter.sv
layer_addr_select.sv
act_format.sv
argmax_classifier.sv
decoder_top.sv
decoder_checker.sv
tb_decoder_top.sv
